// ==== all.f ====
+incdir+include
+incdir+bench
verilog/core_pkg.sv
verilog/reg_file.sv
verilog/inst_decoder.sv
verilog/alu_execute.sv
verilog/commit_stage.sv
verilog/core_top.sv
bench/core_tb.sv

// ==== bench/core_ref.svh ====
// architectural reference model of the core, included inside the testbench module
`ifndef CORE_REF_SVH
`define CORE_REF_SVH

// one expected commit, queued in program order
typedef struct packed {
	pc_t         pc;
	reg_idx_t    dest;
	logic        wr_en;
	word_t       value;
	logic        is_halt;
	logic        is_illegal;
	logic [31:0] due;          // cycle count at which commit_valid should be seen
} exp_commit_t;

word_t model_regs [`CORE_NUM_REGS];    // register state in program order, r31 stays zero

function automatic void clear_model();
	for (int r = 0; r < `CORE_NUM_REGS; r++)
		model_regs[r] = '0;
endfunction

// expected commit of one instruction, retires it into model_regs
function automatic exp_commit_t predict_commit(input inst_t i, input pc_t pc);
	exp_commit_t e;
	logic [5:0]  op;
	logic [6:0]  fn;
	reg_idx_t    rc;
	word_t       a;
	word_t       b;
	logic        known;
	op    = i[`CORE_OP_MSB:`CORE_OP_LSB];
	fn    = i[`CORE_FN_MSB:`CORE_FN_LSB];
	rc    = i[`CORE_RC_MSB:`CORE_RC_LSB];
	a     = model_regs[i[`CORE_RA_MSB:`CORE_RA_LSB]];
	b     = model_regs[i[`CORE_RB_MSB:`CORE_RB_LSB]];
	if (i[`CORE_LIT_FLAG])
		b = word_t'(i[`CORE_LIT_MSB:`CORE_LIT_LSB]);    // literal is zero-extended
	e      = '0;
	e.pc   = pc;
	e.dest = reg_idx_t'(`CORE_ZERO_REG);                // no register named by halt or illegal
	known  = 1'b1;
	case ({op, fn})
		{`CORE_OP_INTA, `CORE_FN_ADDQ}:   e.value = a + b;
		{`CORE_OP_INTA, `CORE_FN_SUBQ}:   e.value = a - b;
		{`CORE_OP_INTA, `CORE_FN_CMPEQ}:  e.value = (a == b) ? 64'd1 : 64'd0;
		{`CORE_OP_INTA, `CORE_FN_CMPULT}: e.value = (a < b) ? 64'd1 : 64'd0;   // unsigned
		{`CORE_OP_INTL, `CORE_FN_AND}:    e.value = a & b;
		{`CORE_OP_INTL, `CORE_FN_BIS}:    e.value = a | b;
		{`CORE_OP_INTL, `CORE_FN_XOR}:    e.value = a ^ b;
		{`CORE_OP_INTS, `CORE_FN_SLL}:    e.value = a << b[5:0];
		{`CORE_OP_INTS, `CORE_FN_SRL}:    e.value = a >> b[5:0];
		default:                          known   = 1'b0;
	endcase
	if (known) begin
		e.dest  = rc;
		e.wr_en = (rc != `CORE_ZERO_REG);
		if (e.wr_en)
			model_regs[rc] = e.value;
	end else begin
		e.value      = '0;
		e.is_halt    = (op == `CORE_OP_PAL) && (i[`CORE_PAL_MSB:`CORE_PAL_LSB] == `CORE_PAL_HALT);
		e.is_illegal = !e.is_halt;
	end
	return e;
endfunction

`endif

// ==== bench/core_tb.sv ====
// testbench for the integer core that drives instruction strobes and checks each commit against the model
`timescale 1ns/1ns
`default_nettype none

`include "core_defines.svh"

module core_tb import core_pkg::*; ();

	`include "core_ref.svh"

	logic          clock;
	logic          arst_n;
	logic          inst_valid;
	inst_t         inst;
	pc_t           inst_pc;
	logic          commit_valid;
	pc_t           commit_pc;
	reg_idx_t      commit_dest;
	logic          commit_wr_en;
	word_t         commit_value;
	error_status_e error_status;

	integer        seed = 89801;
	int unsigned   cycle;            // rising edges seen so far
	int unsigned   mismatches;
	int unsigned   failures;         // missing, unexpected or timed out
	pc_t           next_pc;
	exp_commit_t   exp_q [$];        // commits still in flight
	error_status_e exp_status;

	core_top i_dut (
		.clock        (clock),
		.arst_n       (arst_n),
		.inst_valid   (inst_valid),
		.inst         (inst),
		.inst_pc      (inst_pc),
		.commit_valid (commit_valid),
		.commit_pc    (commit_pc),
		.commit_dest  (commit_dest),
		.commit_wr_en (commit_wr_en),
		.commit_value (commit_value),
		.error_status (error_status)
	);

	always #20 clock = ~clock;                    // 40 ns period
	always @(posedge clock) cycle <= cycle + 1;

	//////////////////////////////////////////////////////////////////////
	// encoding and stimulus helpers
	//////////////////////////////////////////////////////////////////////
	// the nine operations as {opcode, function}
	function automatic logic [12:0] op_fn(input int k);
		case (k)
			0:       return {`CORE_OP_INTA, `CORE_FN_ADDQ};
			1:       return {`CORE_OP_INTA, `CORE_FN_SUBQ};
			2:       return {`CORE_OP_INTA, `CORE_FN_CMPEQ};
			3:       return {`CORE_OP_INTA, `CORE_FN_CMPULT};
			4:       return {`CORE_OP_INTL, `CORE_FN_AND};
			5:       return {`CORE_OP_INTL, `CORE_FN_BIS};
			6:       return {`CORE_OP_INTL, `CORE_FN_XOR};
			7:       return {`CORE_OP_INTS, `CORE_FN_SLL};
			default: return {`CORE_OP_INTS, `CORE_FN_SRL};
		endcase
	endfunction

	function automatic inst_t reg_op(input logic [5:0] op, input logic [6:0] fn,
	                                 input int ra, input int rb, input int rc);
		return {op, 5'(ra), 5'(rb), 3'b000, 1'b0, fn, 5'(rc)};
	endfunction

	function automatic inst_t lit_op(input logic [5:0] op, input logic [6:0] fn,
	                                 input int ra, input logic [7:0] lit, input int rc);
		return {op, 5'(ra), lit, 1'b1, fn, 5'(rc)};
	endfunction

	function automatic logic [7:0] rand_byte();
		return 8'($random(seed));
	endfunction

	function automatic int pick_reg();
		return 20 + ({$random(seed)} % 4);        // small set so most ops depend on each other
	endfunction

	task automatic send(input inst_t i);
		exp_commit_t e;
		@(posedge clock);
		#5;
		inst_valid = 1'b1;
		inst       = i;
		inst_pc    = next_pc;
		e          = predict_commit(i, next_pc);
		e.due      = cycle + 3;                   // commit due on the third edge from here
		exp_q.push_back(e);
		next_pc    = next_pc + 4;
	endtask

	task automatic idle(input int n);
		repeat (n) begin
			@(posedge clock);
			#5;
			inst_valid = 1'b0;
		end
	endtask

	task automatic drain();
		int waited;
		idle(1);
		waited = 0;
		while (exp_q.size() != 0 && waited < 10) begin
			@(negedge clock);
			#1;
			waited++;
		end
		if (exp_q.size() != 0) begin
			$display("%0t ns: timed out with %0d commits outstanding", $time, exp_q.size());
			failures++;
			exp_q.delete();
		end
	endtask

	task automatic apply_reset();
		arst_n     = 1'b0;
		inst_valid = 1'b0;
		clear_model();
		exp_status = NO_ERROR;
		repeat (3) @(posedge clock);
		#5;
		arst_n = 1'b1;
	endtask

	//////////////////////////////////////////////////////////////////////
	// commit checker
	//////////////////////////////////////////////////////////////////////
	task automatic check_commit(input exp_commit_t e);
		assert (cycle == e.due) else begin
			$display("Mismatch at %0t ns: commit_valid cycle expected %0d got %0d",
			         $time, e.due, cycle);
			mismatches++;
		end
		assert (commit_pc == e.pc) else begin
			$display("Mismatch at %0t ns: commit_pc expected %h got %h", $time, e.pc, commit_pc);
			mismatches++;
		end
		assert (commit_dest == e.dest) else begin
			$display("Mismatch at %0t ns: commit_dest expected %0d got %0d",
			         $time, e.dest, commit_dest);
			mismatches++;
		end
		assert (commit_wr_en == e.wr_en) else begin
			$display("Mismatch at %0t ns: commit_wr_en expected %b got %b",
			         $time, e.wr_en, commit_wr_en);
			mismatches++;
		end
		assert (commit_value == e.value) else begin
			$display("Mismatch at %0t ns: commit_value expected %h got %h",
			         $time, e.value, commit_value);
			mismatches++;
		end
	endtask

	initial begin : compare_commits
		exp_commit_t e;
		forever begin
			@(negedge clock);                     // outputs settled half a cycle after the edge
			if (arst_n) begin
				if (commit_valid) begin
					if (exp_q.size() == 0) begin
						$display("%0t ns: commit for pc %h arrived with none expected",
						         $time, commit_pc);
						failures++;
					end else begin
						e = exp_q.pop_front();
						check_commit(e);
						if (exp_status == NO_ERROR && e.is_illegal)
							exp_status = HALTED_ON_ILLEGAL;
						else if (exp_status == NO_ERROR && e.is_halt)
							exp_status = HALTED_ON_HALT;
					end
				end else if (exp_q.size() != 0 && cycle > exp_q[0].due) begin
					$display("%0t ns: commit for pc %h never arrived", $time, exp_q[0].pc);
					failures++;
					void'(exp_q.pop_front());
				end
				assert (error_status == exp_status) else begin
					$display("Mismatch at %0t ns: error_status expected %s got %s",
					         $time, exp_status.name(), error_status.name());
					mismatches++;
				end
			end
		end
	end

	//////////////////////////////////////////////////////////////////////
	// test sequence
	//////////////////////////////////////////////////////////////////////
	initial begin : run_test
		int          k;
		logic [12:0] f;
		clock      = 1'b0;
		arst_n     = 1'b0;
		inst_valid = 1'b0;
		inst       = '0;
		inst_pc    = '0;
		cycle      = 0;
		mismatches = 0;
		failures   = 0;
		next_pc    = 64'h1000;
		apply_reset();

		for (k = 1; k <= 8; k++)                  // r1..r8 from BIS with literal
			send(lit_op(`CORE_OP_INTL, `CORE_FN_BIS, 31, rand_byte(), k));
		send(lit_op(`CORE_OP_INTS, `CORE_FN_SLL, 1, 8'd40, 9));
		send(reg_op(`CORE_OP_INTL, `CORE_FN_BIS, 9, 2, 9));
		for (k = 0; k < 9; k++) begin             // register operands
			f = op_fn(k);
			send(reg_op(f[12:7], f[6:0], 9, k + 1, 10 + k));
		end
		send(reg_op(`CORE_OP_INTA, `CORE_FN_CMPEQ, 3, 3, 19));
		idle(2);
		for (k = 0; k < 18; k++) begin            // random literals
			f = op_fn(k % 9);
			send(lit_op(f[12:7], f[6:0], 1 + ({$random(seed)} % 19), rand_byte(), 10 + k % 9));
		end
		drain();

		// dependences at distance 1, 2, 3 and through the register file
		send(lit_op(`CORE_OP_INTA, `CORE_FN_ADDQ, 1, 8'd1, 20));
		send(reg_op(`CORE_OP_INTA, `CORE_FN_ADDQ, 20, 20, 21));
		send(reg_op(`CORE_OP_INTA, `CORE_FN_SUBQ, 21, 20, 22));
		send(reg_op(`CORE_OP_INTL, `CORE_FN_XOR, 20, 21, 23));
		send(reg_op(`CORE_OP_INTL, `CORE_FN_BIS, 20, 22, 24));
		send(lit_op(`CORE_OP_INTA, `CORE_FN_ADDQ, 20, 8'd5, 20));   // younger rewrite of r20 wins
		send(reg_op(`CORE_OP_INTA, `CORE_FN_ADDQ, 20, 24, 21));
		for (k = 0; k < 40; k++) begin            // gapless random chain
			f = op_fn({$random(seed)} % 9);
			if (k % 3 == 0)
				send(lit_op(f[12:7], f[6:0], pick_reg(), rand_byte(), pick_reg()));
			else
				send(reg_op(f[12:7], f[6:0], pick_reg(), pick_reg(), pick_reg()));
		end
		idle(3);

		// r31 as destination and then as a source
		send(lit_op(`CORE_OP_INTA, `CORE_FN_ADDQ, 1, 8'd7, 31));
		send(reg_op(`CORE_OP_INTL, `CORE_FN_BIS, 31, 31, 25));
		send(reg_op(`CORE_OP_INTA, `CORE_FN_ADDQ, 31, 2, 26));
		drain();

		// illegal first and a later halt that keeps the status
		send(reg_op(`CORE_OP_INTA, 7'h7f, 1, 2, 3));
		send(lit_op(`CORE_OP_INTA, `CORE_FN_ADDQ, 1, 8'd3, 27));
		send({`CORE_OP_PAL, 26'h0});
		send(reg_op(`CORE_OP_INTL, `CORE_FN_XOR, 27, 1, 28));
		drain();

		apply_reset();
		send(lit_op(`CORE_OP_INTL, `CORE_FN_BIS, 31, 8'h5a, 1));
		send({`CORE_OP_PAL, 26'h0});              // halt after a fresh reset
		send({6'h3f, 26'h0});                     // illegal opcode leaves the status on halt
		send(reg_op(`CORE_OP_INTA, `CORE_FN_ADDQ, 1, 1, 2));
		drain();

		$display("summary: %0d mismatches, %0d other errors", mismatches, failures);
		if (mismatches + failures == 0)
			$display("No errors");
		else
			$display("Errors found");
		$finish;
	end

endmodule

`default_nettype wire

// ==== include/core_defines.svh ====
// widths, opcodes, function codes and instruction field positions; include wherever a macro is used
`ifndef CORE_DEFINES_SVH
`define CORE_DEFINES_SVH

`define CORE_WORD_W    64       // datapath and pc width
`define CORE_INST_W    32       // instruction word
`define CORE_NUM_REGS  32       // architectural registers
`define CORE_ZERO_REG  31       // hardwired zero register

// major opcodes
`define CORE_OP_PAL    6'h00
`define CORE_OP_INTA   6'h10    // add, sub, compare
`define CORE_OP_INTL   6'h11    // logical
`define CORE_OP_INTS   6'h12    // shifts

// operate-format function codes
`define CORE_FN_ADDQ   7'h20
`define CORE_FN_SUBQ   7'h29
`define CORE_FN_CMPEQ  7'h2d
`define CORE_FN_CMPULT 7'h1d
`define CORE_FN_AND    7'h00
`define CORE_FN_BIS    7'h20
`define CORE_FN_XOR    7'h40
`define CORE_FN_SLL    7'h39
`define CORE_FN_SRL    7'h34
`define CORE_PAL_HALT  26'h0    // palcode of halt

// instruction field positions
`define CORE_OP_MSB    31
`define CORE_OP_LSB    26
`define CORE_RA_MSB    25
`define CORE_RA_LSB    21
`define CORE_RB_MSB    20
`define CORE_RB_LSB    16
`define CORE_LIT_MSB   20
`define CORE_LIT_LSB   13
`define CORE_LIT_FLAG  12
`define CORE_FN_MSB    11
`define CORE_FN_LSB    5
`define CORE_RC_MSB    4
`define CORE_RC_LSB    0
`define CORE_PAL_MSB   25       // palcode spans everything below the opcode
`define CORE_PAL_LSB   0

`endif

// ==== verilog/alu_execute.sv ====
// execute stage: integer alu on the decoded packet, result bypassed and registered
`timescale 1ns/1ns
`default_nettype none

`include "core_defines.svh"

module alu_execute import core_pkg::*; (
	input  wire          clock,
	input  wire          arst_n,
	input  wire dec_op_t dec_op,
	output fwd_t         alu_fwd,     // same-cycle bypass to decode
	output exe_res_t     exe_res      // to commit and register file write
);

	localparam int SHAMT_W = $clog2(`CORE_WORD_W);   // 6 bits for 64-bit words

	word_t               result;
	logic [SHAMT_W-1:0]  shamt;

	assign shamt = dec_op.opb[SHAMT_W-1:0];

	//////////////////////////////////////////////////////////////////////
	// alu
	//////////////////////////////////////////////////////////////////////
	always_comb begin
		case (dec_op.func)
			ALU_ADDQ:   result = dec_op.opa + dec_op.opb;
			ALU_SUBQ:   result = dec_op.opa - dec_op.opb;
			ALU_CMPEQ:  result = word_t'(dec_op.opa == dec_op.opb);
			ALU_CMPULT: result = word_t'(dec_op.opa < dec_op.opb);    // unsigned compare
			ALU_AND:    result = dec_op.opa & dec_op.opb;
			ALU_BIS:    result = dec_op.opa | dec_op.opb;
			ALU_XOR:    result = dec_op.opa ^ dec_op.opb;
			ALU_SLL:    result = dec_op.opa << shamt;
			ALU_SRL:    result = dec_op.opa >> shamt;                 // logical
			default:    result = '0;
		endcase
		if (dec_op.is_halt || dec_op.is_illegal)
			result = '0;    // these commit a zero value
	end

	// bypass for the instruction now in decode
	assign alu_fwd.valid = dec_op.valid;
	assign alu_fwd.wr_en = dec_op.wr_en;
	assign alu_fwd.dest  = dec_op.dest;
	assign alu_fwd.value = result;

	//////////////////////////////////////////////////////////////////////
	// result register
	//////////////////////////////////////////////////////////////////////
	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			exe_res <= '0;
		end else begin
			exe_res.valid      <= dec_op.valid;
			exe_res.pc         <= dec_op.pc;
			exe_res.dest       <= dec_op.dest;
			exe_res.wr_en      <= dec_op.wr_en;
			exe_res.value      <= result;
			exe_res.is_halt    <= dec_op.is_halt;
			exe_res.is_illegal <= dec_op.is_illegal;
		end
	end

endmodule

`default_nettype wire

// ==== verilog/commit_stage.sv ====
// commit stage: registers the architectural commit report and keeps the sticky error status
`timescale 1ns/1ns
`default_nettype none

module commit_stage import core_pkg::*; (
	input  wire           clock,
	input  wire           arst_n,
	input  wire exe_res_t exe_res,
	output logic          commit_valid,   // one-cycle strobe per instruction
	output pc_t           commit_pc,
	output reg_idx_t      commit_dest,
	output logic          commit_wr_en,
	output word_t         commit_value,
	output error_status_e error_status
);

	error_status_e status_next;

	//////////////////////////////////////////////////////////////////////
	// error status fsm
	//////////////////////////////////////////////////////////////////////
	always_comb begin
		status_next = error_status;                      // hold once left NO_ERROR
		if (error_status == NO_ERROR && exe_res.valid) begin
			if (exe_res.is_illegal)
				status_next = HALTED_ON_ILLEGAL;
			else if (exe_res.is_halt)
				status_next = HALTED_ON_HALT;
		end
	end

	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			error_status <= NO_ERROR;
			commit_valid <= 1'b0;
			commit_wr_en <= 1'b0;
		end else begin
			error_status <= status_next;
			commit_valid <= exe_res.valid;
			commit_wr_en <= exe_res.valid && exe_res.wr_en;  // low for halt, illegal, r31
		end
	end

	// commit payload, qualified by commit_valid
	always_ff @(posedge clock) begin
		commit_pc    <= exe_res.pc;
		commit_dest  <= exe_res.dest;
		commit_value <= exe_res.value;
	end

endmodule

`default_nettype wire

// ==== verilog/core_pkg.sv ====
// shared types of the core pipeline; modules pull them in with a wildcard import
`default_nettype none

`include "core_defines.svh"

package core_pkg;

	//////////////////////////////////////////////////////////////////////
	// plain vector types
	//////////////////////////////////////////////////////////////////////
	typedef logic [`CORE_WORD_W-1:0]            word_t;     // data word
	typedef logic [`CORE_WORD_W-1:0]            pc_t;       // instruction address
	typedef logic [`CORE_INST_W-1:0]            inst_t;     // raw instruction
	typedef logic [$clog2(`CORE_NUM_REGS)-1:0] reg_idx_t;  // architectural register number

	// alu operation picked by the decoder
	typedef enum logic [3:0] {
		ALU_ADDQ,
		ALU_SUBQ,
		ALU_CMPEQ,
		ALU_CMPULT,
		ALU_AND,
		ALU_BIS,
		ALU_XOR,
		ALU_SLL,
		ALU_SRL
	} alu_func_e;

	// sticky commit-side status, leaves NO_ERROR once
	typedef enum logic [1:0] {
		NO_ERROR          = 2'd0,
		HALTED_ON_HALT    = 2'd1,
		HALTED_ON_ILLEGAL = 2'd2
	} error_status_e;

	//////////////////////////////////////////////////////////////////////
	// stage packets
	//////////////////////////////////////////////////////////////////////
	typedef struct packed {
		logic      valid;       // slot holds an instruction
		pc_t       pc;
		alu_func_e func;
		word_t     opa;         // forwarded ra value
		word_t     opb;         // literal or forwarded rb value
		reg_idx_t  dest;        // rc
		logic      wr_en;       // legal operate with rc != 31
		logic      is_halt;
		logic      is_illegal;
	} dec_op_t;

	typedef struct packed {
		logic     valid;
		pc_t      pc;
		reg_idx_t dest;
		logic     wr_en;
		word_t    value;        // zero for halt and illegal
		logic     is_halt;
		logic     is_illegal;
	} exe_res_t;

	// bypass source seen by the decoder
	typedef struct packed {
		logic     valid;
		logic     wr_en;
		reg_idx_t dest;
		word_t    value;
	} fwd_t;

endpackage

`default_nettype wire

// ==== verilog/core_top.sv ====
// top level of the in-order integer core: decode, execute, commit and the register file
`timescale 1ns/1ns
`default_nettype none

module core_top import core_pkg::*; (
	input  wire           clock,
	input  wire           arst_n,
	input  wire           inst_valid,    // sampled at the rising edge
	input  wire inst_t    inst,
	input  wire pc_t      inst_pc,
	output logic          commit_valid,  // 3 edges after inst_valid
	output pc_t           commit_pc,
	output reg_idx_t      commit_dest,
	output logic          commit_wr_en,
	output word_t         commit_value,
	output error_status_e error_status
);

	reg_idx_t ra_idx;
	reg_idx_t rb_idx;
	word_t    ra_data;
	word_t    rb_data;
	dec_op_t  dec_op;
	exe_res_t exe_res;
	fwd_t     alu_fwd;
	fwd_t     exe_fwd;

	// second bypass source is just the execute register
	assign exe_fwd.valid = exe_res.valid;
	assign exe_fwd.wr_en = exe_res.wr_en;
	assign exe_fwd.dest  = exe_res.dest;
	assign exe_fwd.value = exe_res.value;

	//////////////////////////////////////////////////////////////////////
	// stages
	//////////////////////////////////////////////////////////////////////
	reg_file i_reg_file (
		.clock    (clock),
		.arst_n   (arst_n),
		.ra_idx   (ra_idx),
		.rb_idx   (rb_idx),
		.ra_data  (ra_data),
		.rb_data  (rb_data),
		.wr_valid (exe_res.valid && exe_res.wr_en),   // same edge as commit load
		.wr_idx   (exe_res.dest),
		.wr_data  (exe_res.value)
	);

	inst_decoder i_inst_decoder (
		.clock      (clock),
		.arst_n     (arst_n),
		.inst_valid (inst_valid),
		.inst       (inst),
		.inst_pc    (inst_pc),
		.ra_idx     (ra_idx),
		.rb_idx     (rb_idx),
		.ra_data    (ra_data),
		.rb_data    (rb_data),
		.alu_fwd    (alu_fwd),
		.exe_fwd    (exe_fwd),
		.dec_op     (dec_op)
	);

	alu_execute i_alu_execute (
		.clock   (clock),
		.arst_n  (arst_n),
		.dec_op  (dec_op),
		.alu_fwd (alu_fwd),
		.exe_res (exe_res)
	);

	commit_stage i_commit_stage (
		.clock        (clock),
		.arst_n       (arst_n),
		.exe_res      (exe_res),
		.commit_valid (commit_valid),
		.commit_pc    (commit_pc),
		.commit_dest  (commit_dest),
		.commit_wr_en (commit_wr_en),
		.commit_value (commit_value),
		.error_status (error_status)
	);

endmodule

`default_nettype wire

// ==== verilog/inst_decoder.sv ====
// decode stage: splits the instruction, forwards operands and registers the decoded packet
`timescale 1ns/1ns
`default_nettype none

`include "core_defines.svh"

module inst_decoder import core_pkg::*; (
	input  wire           clock,
	input  wire           arst_n,
	input  wire           inst_valid,   // single-cycle strobe
	input  wire inst_t    inst,
	input  wire pc_t      inst_pc,
	output reg_idx_t      ra_idx,       // to register file
	output reg_idx_t      rb_idx,
	input  wire word_t    ra_data,
	input  wire word_t    rb_data,
	input  wire fwd_t     alu_fwd,      // youngest, combinational alu result
	input  wire fwd_t     exe_fwd,      // registered execute result
	output dec_op_t       dec_op
);

	localparam reg_idx_t ZERO_IDX = reg_idx_t'(`CORE_ZERO_REG);

	logic [`CORE_OP_MSB-`CORE_OP_LSB:0]   opcode;
	logic [`CORE_FN_MSB-`CORE_FN_LSB:0]   func;
	logic [`CORE_LIT_MSB-`CORE_LIT_LSB:0] literal;
	logic [`CORE_PAL_MSB-`CORE_PAL_LSB:0] palcode;
	reg_idx_t rc;
	logic     legal_op;                  // recognised operate instruction
	dec_op_t  dec_next;

	// youngest writer wins, r31 is never forwarded
	function automatic word_t fwd_pick(input reg_idx_t idx, input word_t rf_val);
		if (idx == ZERO_IDX)
			return '0;
		if (alu_fwd.valid && alu_fwd.wr_en && (alu_fwd.dest == idx))
			return alu_fwd.value;
		if (exe_fwd.valid && exe_fwd.wr_en && (exe_fwd.dest == idx))
			return exe_fwd.value;
		return rf_val;
	endfunction

	//////////////////////////////////////////////////////////////////////
	// field split
	//////////////////////////////////////////////////////////////////////
	assign opcode  = inst[`CORE_OP_MSB:`CORE_OP_LSB];
	assign func    = inst[`CORE_FN_MSB:`CORE_FN_LSB];
	assign literal = inst[`CORE_LIT_MSB:`CORE_LIT_LSB];
	assign palcode = inst[`CORE_PAL_MSB:`CORE_PAL_LSB];
	assign rc      = inst[`CORE_RC_MSB:`CORE_RC_LSB];
	assign ra_idx  = inst[`CORE_RA_MSB:`CORE_RA_LSB];
	assign rb_idx  = inst[`CORE_RB_MSB:`CORE_RB_LSB];

	//////////////////////////////////////////////////////////////////////
	// decode and operand select
	//////////////////////////////////////////////////////////////////////
	always_comb begin
		dec_next            = '0;
		dec_next.func       = ALU_ADDQ;
		legal_op            = 1'b1;
		case (opcode)
			`CORE_OP_INTA: begin
				case (func)
					`CORE_FN_ADDQ:   dec_next.func = ALU_ADDQ;
					`CORE_FN_SUBQ:   dec_next.func = ALU_SUBQ;
					`CORE_FN_CMPEQ:  dec_next.func = ALU_CMPEQ;
					`CORE_FN_CMPULT: dec_next.func = ALU_CMPULT;
					default:         legal_op      = 1'b0;
				endcase
			end
			`CORE_OP_INTL: begin
				case (func)
					`CORE_FN_AND: dec_next.func = ALU_AND;
					`CORE_FN_BIS: dec_next.func = ALU_BIS;
					`CORE_FN_XOR: dec_next.func = ALU_XOR;
					default:      legal_op      = 1'b0;
				endcase
			end
			`CORE_OP_INTS: begin
				case (func)
					`CORE_FN_SLL: dec_next.func = ALU_SLL;
					`CORE_FN_SRL: dec_next.func = ALU_SRL;
					default:      legal_op      = 1'b0;
				endcase
			end
			`CORE_OP_PAL: begin
				legal_op         = 1'b0;
				dec_next.is_halt = (palcode == `CORE_PAL_HALT);
			end
			default: legal_op = 1'b0;
		endcase
		dec_next.is_illegal = !legal_op && !dec_next.is_halt;
		dec_next.valid      = inst_valid;
		dec_next.pc         = inst_pc;
		dec_next.opa        = fwd_pick(ra_idx, ra_data);
		dec_next.opb        = inst[`CORE_LIT_FLAG] ? word_t'(literal)    // zero-extended literal
		                                           : fwd_pick(rb_idx, rb_data);
		dec_next.dest       = legal_op ? rc : ZERO_IDX;    // halt and illegal name no register
		dec_next.wr_en      = inst_valid && legal_op && (rc != ZERO_IDX);
	end

	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n)
			dec_op <= '0;               // empty slot
		else
			dec_op <= dec_next;         // bubble when no strobe
	end

endmodule

`default_nettype wire

// ==== verilog/reg_file.sv ====
// architectural register file, two combinational reads and one clocked write port
`timescale 1ns/1ns
`default_nettype none

`include "core_defines.svh"

module reg_file import core_pkg::*; (
	input  wire           clock,
	input  wire           arst_n,
	input  wire reg_idx_t ra_idx,      // read port a
	input  wire reg_idx_t rb_idx,      // read port b
	output word_t         ra_data,
	output word_t         rb_data,
	input  wire           wr_valid,    // write strobe from the execute register
	input  wire reg_idx_t wr_idx,
	input  wire word_t    wr_data
);

	localparam reg_idx_t ZERO_IDX = reg_idx_t'(`CORE_ZERO_REG);

	word_t regs [`CORE_NUM_REGS];      // storage, r31 never written

	//////////////////////////////////////////////////////////////////////
	// write port
	//////////////////////////////////////////////////////////////////////
	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			for (int i = 0; i < `CORE_NUM_REGS; i++) begin
				regs[i] <= '0;           // all registers read zero after reset
			end
		end else if (wr_valid && (wr_idx != ZERO_IDX)) begin
			regs[wr_idx] <= wr_data;     // writes to r31 dropped
		end
	end

	//////////////////////////////////////////////////////////////////////
	// read ports
	//////////////////////////////////////////////////////////////////////
	// no internal bypass, the decoder forwards from the younger stages
	assign ra_data = (ra_idx == ZERO_IDX) ? '0 : regs[ra_idx];
	assign rb_data = (rb_idx == ZERO_IDX) ? '0 : regs[rb_idx];

endmodule

`default_nettype wire
